// File: hw/spi_pkg.sv
//--------------------------------------------------
// spi frame format
// constants shared by the serial receiver and the
// register decode: frame length and field widths
//--------------------------------------------------
package spi_pkg;

  // a valid frame is exactly this many bits while cs_n is low
  localparam int FRAME_BITS = 16;

  // address byte goes first on the wire, msb first
  localparam int ADDR_BITS = 8;

  // data byte follows the address
  localparam int DATA_BITS = 8;

  // bit counter must reach FRAME_BITS and saturate above it (31)
  localparam int CNT_BITS = 5;

endpackage

// File: hw/led_pkg.sv
//--------------------------------------------------
// led register map
// register addresses, control bit positions and the
// widths of the led, rate and blink counter fields
//--------------------------------------------------
package led_pkg;

  // two board leds
  localparam int LED_COUNT = 2;

  // rate selects a shift of 0..15
  localparam int RATE_BITS = 4;

  // largest shift (15) plus the two step bits
  localparam int CNT_WIDTH = 17;

  // register addresses, same width as the frame address field
  localparam logic [spi_pkg::ADDR_BITS-1:0] ADDR_CTRL = 0;
  localparam logic [spi_pkg::ADDR_BITS-1:0] ADDR_LED  = 1;
  localparam logic [spi_pkg::ADDR_BITS-1:0] ADDR_RATE = 2;

  // control word bits
  // counter advances while set
  localparam int CTRL_RUN     = 0;
  // gray coded pattern when set, binary otherwise
  localparam int CTRL_GRAY    = 1;
  // one-shot counter clear, not stored
  localparam int CTRL_RESTART = 2;
  // 1 shows the pattern, 0 shows the manual value
  localparam int CTRL_SRC     = 3;

endpackage

// File: hw/blink_cfg_if.sv
//--------------------------------------------------
// blink configuration
// carries the register state to the pattern generator
//--------------------------------------------------
`timescale 1ns/1ns

interface blink_cfg_if;

  // levels held by the register block
  logic                          run;
  logic                          gray;
  logic                          src_pattern;
  // single cycle pulse
  logic                          restart;
  logic [led_pkg::RATE_BITS-1:0] rate;
  logic [led_pkg::LED_COUNT-1:0] manual;

  modport regs (output run, gray, src_pattern, restart, rate, manual);
  modport gen  (input  run, gray, src_pattern, restart, rate, manual);

endinterface

// File: hw/spi_frame_rx.sv
//--------------------------------------------------
// spi frame receiver
// oversamples sclk, cs_n and mosi on clk, shifts in
// mode 0 frames and strobes out address and data when
// exactly FRAME_BITS bits arrived
//--------------------------------------------------
`timescale 1ns/1ns

module spi_frame_rx (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sclk,
  input  logic                          cs_n,
  input  logic                          mosi,
  output logic                          wr_strobe,
  output logic [spi_pkg::ADDR_BITS-1:0] wr_addr,
  output logic [spi_pkg::DATA_BITS-1:0] wr_data
);

  // two flop synchronizers, [1] is the usable copy
  logic [1:0] sclk_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;

  // previous synchronized levels for edge detection
  logic sclk_d;
  logic cs_d;

  logic sclk_rise;
  logic cs_fall;
  logic cs_rise;

  logic [spi_pkg::FRAME_BITS-1:0] shift_reg;
  logic [spi_pkg::CNT_BITS-1:0]   bit_cnt;
  logic                           frame_ok;

  // control pins reset to idle: sclk low, cs_n high
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sclk_sync <= '0;
      cs_sync   <= '1;
      sclk_d    <= 1'b0;
      cs_d      <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs_n};
      sclk_d    <= sclk_sync[1];
      cs_d      <= cs_sync[1];
    end
  end

  // mosi has the same delay as sclk so it lines up with sclk_rise
  always_ff @(posedge clk)
  begin
    mosi_sync <= {mosi_sync[0], mosi};
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_d;
  assign cs_fall   = ~cs_sync[1] & cs_d;
  assign cs_rise   = cs_sync[1] & ~cs_d;

  // frame is good only at the exact length
  assign frame_ok = (bit_cnt == spi_pkg::CNT_BITS'(spi_pkg::FRAME_BITS));

  // bit counter, cleared at frame start, saturates at all ones
  always_ff @(posedge clk)
  begin
    if (reset)
      bit_cnt <= '0;
    else if (cs_fall)
      bit_cnt <= '0;
    else if (sclk_rise && !cs_sync[1] && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // msb first, new bit enters at the bottom
  always_ff @(posedge clk)
  begin
    if (sclk_rise && !cs_sync[1])
      shift_reg <= {shift_reg[spi_pkg::FRAME_BITS-2:0], mosi_sync[1]};
  end

  // commit on cs_n rising, one cycle after the edge is seen
  always_ff @(posedge clk)
  begin
    if (reset)
      wr_strobe <= 1'b0;
    else
      wr_strobe <= cs_rise & frame_ok;
  end

  // address is the first byte in, so it sits in the upper half
  always_ff @(posedge clk)
  begin
    if (cs_rise && frame_ok)
    begin
      wr_addr <= shift_reg[spi_pkg::FRAME_BITS-1 -: spi_pkg::ADDR_BITS];
      wr_data <= shift_reg[spi_pkg::DATA_BITS-1:0];
    end
  end

endmodule

// File: hw/led_regs.sv
//--------------------------------------------------
// led register block
// decodes write strobes into control, manual value
// and rate, and drives the blink configuration
//--------------------------------------------------
`timescale 1ns/1ns

module led_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wr_strobe,
  input  logic [spi_pkg::ADDR_BITS-1:0] wr_addr,
  input  logic [spi_pkg::DATA_BITS-1:0] wr_data,
  blink_cfg_if.regs                     cfg
);

  // address decode, only meaningful during the strobe
  logic wr_ctrl;
  logic wr_led;
  logic wr_rate;

  assign wr_ctrl = wr_strobe && (wr_addr == led_pkg::ADDR_CTRL);
  assign wr_led  = wr_strobe && (wr_addr == led_pkg::ADDR_LED);
  assign wr_rate = wr_strobe && (wr_addr == led_pkg::ADDR_RATE);

  // control word levels
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cfg.run         <= 1'b0;
      cfg.gray        <= 1'b0;
      cfg.src_pattern <= 1'b0;
    end
    else if (wr_ctrl)
    begin
      cfg.run         <= wr_data[led_pkg::CTRL_RUN];
      cfg.gray        <= wr_data[led_pkg::CTRL_GRAY];
      cfg.src_pattern <= wr_data[led_pkg::CTRL_SRC];
    end
  end

  // restart is not stored
  // it is high only on the cycle after the control write
  always_ff @(posedge clk)
  begin
    if (reset)
      cfg.restart <= 1'b0;
    else
      cfg.restart <= wr_ctrl && wr_data[led_pkg::CTRL_RESTART];
  end

  // manual led value, low bits of the data byte
  always_ff @(posedge clk)
  begin
    if (reset)
      cfg.manual <= '0;
    else if (wr_led)
      cfg.manual <= wr_data[led_pkg::LED_COUNT-1:0];
  end

  // blink rate as a shift amount
  always_ff @(posedge clk)
  begin
    if (reset)
      cfg.rate <= '0;
    else if (wr_rate)
      cfg.rate <= wr_data[led_pkg::RATE_BITS-1:0];
  end

  // writes to any other address fall through all decodes

endmodule

// File: hw/led_pattern_gen.sv
//--------------------------------------------------
// led pattern generator
// free running blink counter, gray or binary step
// and selection between pattern and manual value
//--------------------------------------------------
`timescale 1ns/1ns

module led_pattern_gen (
  input  logic                          clk,
  input  logic                          reset,
  blink_cfg_if.gen                      cfg,
  output logic [led_pkg::LED_COUNT-1:0] led
);

  logic [led_pkg::CNT_WIDTH-1:0] blink_cnt;
  logic [led_pkg::CNT_WIDTH-1:0] cnt_shifted;
  logic [led_pkg::LED_COUNT-1:0] step;
  logic [led_pkg::LED_COUNT-1:0] step_gray;
  logic [led_pkg::LED_COUNT-1:0] pattern;

  // restart wins over run
  always_ff @(posedge clk)
  begin
    if (reset)
      blink_cnt <= '0;
    else if (cfg.restart)
      blink_cnt <= '0;
    else if (cfg.run)
      blink_cnt <= blink_cnt + 1'b1;
  end

  // step advances every 2**rate cycles
  assign cnt_shifted = blink_cnt >> cfg.rate;
  assign step        = cnt_shifted[led_pkg::LED_COUNT-1:0];

  // binary to gray, neighbours differ in one bit
  assign step_gray = step ^ (step >> 1);
  assign pattern   = cfg.gray ? step_gray : step;

  // registered output
  always_ff @(posedge clk)
  begin
    if (reset)
      led <= '0;
    else if (cfg.src_pattern)
      led <= pattern;
    else
      led <= cfg.manual;
  end

endmodule

// File: hw/led_spi_top.sv
//--------------------------------------------------
// spi controlled led top level
// serial receiver, register block and pattern
// generator on a single system clock
//--------------------------------------------------
`timescale 1ns/1ns

module led_spi_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sclk,
  input  logic                          cs_n,
  input  logic                          mosi,
  output logic [led_pkg::LED_COUNT-1:0] led
);

  // write port from the receiver to the registers
  logic                          wr_strobe;
  logic [spi_pkg::ADDR_BITS-1:0] wr_addr;
  logic [spi_pkg::DATA_BITS-1:0] wr_data;

  // configuration from the registers to the generator
  blink_cfg_if blink_cfg ();

  // pins are sampled on clk, sclk is never used as a clock
  spi_frame_rx spi_frame_rx_inst (
    .clk       (clk),
    .reset     (reset),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .wr_strobe (wr_strobe),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  led_regs led_regs_inst (
    .clk       (clk),
    .reset     (reset),
    .wr_strobe (wr_strobe),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .cfg       (blink_cfg.regs)
  );

  led_pattern_gen led_pattern_gen_inst (
    .clk   (clk),
    .reset (reset),
    .cfg   (blink_cfg.gen),
    .led   (led)
  );

endmodule

// File: test/led_spi_asserts.sv
//--------------------------------------------------
// led spi assertions
// write strobe shape in the receiver and single bit
// steps of the gray led pattern
//--------------------------------------------------
`timescale 1ns/1ns

module led_spi_asserts (
  input logic                          clk,
  input logic                          reset,
  input logic                          wr_strobe,
  input logic                          cs_n,
  input logic [led_pkg::LED_COUNT-1:0] led,
  input logic                          gray,
  input logic                          src_pattern,
  input logic                          restart,
  input logic [led_pkg::RATE_BITS-1:0] rate
);

  // strobe is a single cycle pulse
  assert property (@(posedge clk) disable iff (reset) wr_strobe |=> !wr_strobe)
    else $error("wr_strobe high two cycles in a row");

  // strobe comes three cycles after cs_n rises at the pin
  assert property (@(posedge clk) disable iff (reset)
    wr_strobe |-> ($past(cs_n, 3) && !$past(cs_n, 4)))
    else $error("wr_strobe without a cs_n rising edge");

  // rate change or restart may jump the step, so those cycles are skipped
  assert property (@(posedge clk) disable iff (reset)
    (gray && src_pattern && $past(gray) && $past(src_pattern)
      && rate == $past(rate) && !$past(restart))
    |=> ($countones(led ^ $past(led)) <= 1))
    else $error("gray led pattern changed more than one bit");

endmodule

// receiver side, led inputs tied off
bind spi_frame_rx led_spi_asserts rx_asserts (
  .clk         (clk),
  .reset       (reset),
  .wr_strobe   (wr_strobe),
  .cs_n        (cs_n),
  .led         ('0),
  .gray        (1'b0),
  .src_pattern (1'b0),
  .restart     (1'b0),
  .rate        ('0)
);

// generator side, strobe inputs tied off
bind led_pattern_gen led_spi_asserts gen_asserts (
  .clk         (clk),
  .reset       (reset),
  .wr_strobe   (1'b0),
  .cs_n        (1'b1),
  .led         (led),
  .gray        (cfg.gray),
  .src_pattern (cfg.src_pattern),
  .restart     (cfg.restart),
  .rate        (cfg.rate)
);

// File: test/led_spi_tb.sv
//--------------------------------------------------
// spi led testbench
// sends serial frames to the led top level, models
// the register state and checks led every cycle
//--------------------------------------------------
`timescale 1ns/1ns

module led_spi_tb;

  localparam int MAX_CYCLES = 20000;

  logic                          clk;
  logic                          reset;
  logic                          sclk;
  logic                          cs_n;
  logic                          mosi;
  logic [led_pkg::LED_COUNT-1:0] led;

  // model of the register state seen at led
  logic                          m_src;
  logic                          m_gray;
  logic [led_pkg::LED_COUNT-1:0] m_manual;
  logic [led_pkg::RATE_BITS-1:0] m_rate;
  // pattern step 0 starts at edge pat_start, count stops at pat_stop
  int pat_start;
  int pat_stop;
  logic check_en;

  int cycle;
  int errors;
  int checks;
  int seed;
  int i;
  int r;
  int start_edge;
  logic [spi_pkg::DATA_BITS-1:0] data;
  logic [spi_pkg::ADDR_BITS-1:0] addr;

  led_spi_top led_spi_top_inst (
    .clk   (clk),
    .reset (reset),
    .sclk  (sclk),
    .cs_n  (cs_n),
    .mosi  (mosi),
    .led   (led)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // gray order is 0 1 3 2, binary is 0 1 2 3
  function automatic logic [led_pkg::LED_COUNT-1:0] expect_led(
    input logic                          src,
    input logic                          gray,
    input logic [led_pkg::LED_COUNT-1:0] manual,
    input int                            step
  );
    logic [led_pkg::LED_COUNT-1:0] val;
    if (!src)
      return manual;
    case (step % 4)
      0:       val = 2'd0;
      1:       val = 2'd1;
      2:       val = gray ? 2'd3 : 2'd2;
      default: val = gray ? 2'd2 : 2'd3;
    endcase
    return val;
  endfunction

  function automatic logic [7:0] ctrl_byte(
    input logic run,
    input logic gray,
    input logic src,
    input logic restart
  );
    logic [7:0] b;
    b = '0;
    b[led_pkg::CTRL_RUN]     = run;
    b[led_pkg::CTRL_GRAY]    = gray;
    b[led_pkg::CTRL_SRC]     = src;
    b[led_pkg::CTRL_RESTART] = restart;
    return b;
  endfunction

  // returns 1 ns after the n-th rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // msb first, mode 0, each sclk phase 4 clk cycles
  // returns right after cs_n goes high
  task automatic spi_frame(input logic [31:0] bits, input int nbits);
    cs_n = 1'b0;
    for (int b = nbits - 1; b >= 0; b--)
    begin
      mosi = bits[b];
      wait_cycles(4);
      sclk = 1'b1;
      wait_cycles(4);
      sclk = 1'b0;
    end
    wait_cycles(4);
    cs_n = 1'b1;
  endtask

  task automatic finish_run;
    $display("led_spi_tb: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  endtask

  // compare on the falling edge, away from the driven edges
  always @(negedge clk)
  begin : compare_led
    int j;
    logic [led_pkg::LED_COUNT-1:0] exp_led;
    if (check_en)
    begin
      j = cycle - pat_start;
      if (j > pat_stop)
        j = pat_stop;
      exp_led = expect_led(m_src, m_gray, m_manual, j >> m_rate);
      checks = checks + 1;
      if (led !== exp_led)
      begin
        errors = errors + 1;
        $display("Error led: expected %h, actual %h at cycle %0d", exp_led, led, cycle);
      end
    end
  end

  // edge counter and run limit
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle == MAX_CYCLES)
    begin
      errors = errors + 1;
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      finish_run();
    end
  end

  initial
  begin
    seed      = 41099;
    cycle     = 0;
    errors    = 0;
    checks    = 0;
    reset     = 1'b1;
    sclk      = 1'b0;
    cs_n      = 1'b1;
    mosi      = 1'b0;
    check_en  = 1'b0;
    m_src     = 1'b0;
    m_gray    = 1'b0;
    m_manual  = '0;
    m_rate    = '0;
    pat_start = 0;
    pat_stop  = MAX_CYCLES;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;

    // idle after reset, led stays 0
    check_en = 1'b1;
    wait_cycles(50);

    // manual writes land 5 cycles after cs_n rises
    for (i = 0; i < 8; i++)
    begin
      data = $random(seed);
      if (data[1:0] == m_manual)
        data[1:0] = ~m_manual;
      spi_frame({led_pkg::ADDR_LED, data}, 16);
      wait_cycles(5);
      m_manual = data[1:0];
      wait_cycles(3);
    end

    // short, long and unused address frames are dropped
    data = $random(seed);
    if (data[1:0] == m_manual)
      data[1:0] = ~m_manual;
    spi_frame({led_pkg::ADDR_LED, data} >> 1, 15);
    wait_cycles(8);
    // last 16 bits form a valid led write
    spi_frame({1'b1, led_pkg::ADDR_LED, data}, 17);
    wait_cycles(8);
    addr = 8'h03 + ($random(seed) & 8'h7f);
    spi_frame({addr, data}, 16);
    wait_cycles(8);

    // gray pattern at rates 0..3, two full loops each
    for (r = 0; r < 4; r++)
    begin
      check_en = 1'b0;
      spi_frame({led_pkg::ADDR_RATE, 8'(r)}, 16);
      wait_cycles(5);
      m_rate = r;
      spi_frame({led_pkg::ADDR_CTRL, ctrl_byte(1'b1, 1'b1, 1'b1, 1'b1)}, 16);
      start_edge = cycle;
      // counter cleared at edge +5, first step shown at edge +6
      wait_cycles(6);
      m_src     = 1'b1;
      m_gray    = 1'b1;
      pat_start = start_edge + 6;
      pat_stop  = MAX_CYCLES;
      check_en  = 1'b1;
      wait_cycles(8 << r);
    end

    // binary pattern at rate 1, then stop the counter
    check_en = 1'b0;
    spi_frame({led_pkg::ADDR_RATE, 8'd1}, 16);
    wait_cycles(5);
    m_rate = 1;
    spi_frame({led_pkg::ADDR_CTRL, ctrl_byte(1'b1, 1'b0, 1'b1, 1'b1)}, 16);
    start_edge = cycle;
    wait_cycles(6);
    m_gray    = 1'b0;
    pat_start = start_edge + 6;
    pat_stop  = MAX_CYCLES;
    check_en  = 1'b1;
    wait_cycles(24);
    spi_frame({led_pkg::ADDR_CTRL, ctrl_byte(1'b0, 1'b0, 1'b1, 1'b0)}, 16);
    // last increment happens at edge +4 after cs_n rises
    pat_stop = cycle - start_edge - 1;
    wait_cycles(40);

    // back to the stored manual value
    spi_frame({led_pkg::ADDR_CTRL, ctrl_byte(1'b0, 1'b0, 1'b0, 1'b0)}, 16);
    wait_cycles(5);
    m_src = 1'b0;
    wait_cycles(20);

    finish_run();
  end

endmodule

// File: src.f
hw/spi_pkg.sv
hw/led_pkg.sv
hw/blink_cfg_if.sv
hw/spi_frame_rx.sv
hw/led_regs.sv
hw/led_pattern_gen.sv
hw/led_spi_top.sv
test/led_spi_asserts.sv
test/led_spi_tb.sv
